// ==== flist.f ====
+incdir+include
rtl/cx4_pkg.sv
rtl/cx4_host_port.sv
rtl/cx4_mmio_regs.sv
rtl/cx4_dma_engine.sv
rtl/cx4_cache_fill.sv
rtl/cx4_dual_ram.sv
rtl/cx4_top.sv
verification/cx4_bus_model.sv
verification/cx4_tb.sv

// ==== include/cx4_defs_defs.svh ====
`ifndef CX4_DEFS_DEFS_SVH
`define CX4_DEFS_DEFS_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////
`define CX4_ADDR_W          13
`define CX4_DATA_W          8
`define CX4_WORD_W          24
`define CX4_BUS_ADDR_W      23     // bit 15 dropped
`define CX4_DATRAM_BYTES    3072
`define CX4_DATRAM_AW       12
`define CX4_PGM_AW          10     // two slots
`define CX4_PAGE_AW         9      // 512 byte page
`define CX4_PAGE_NUM_W      15

////////////////////////////////////////
// register window
////////////////////////////////////////
`define CX4_MMIO_BASE       13'h1f40
`define CX4_MMIO_LAST       5'h19
`define CX4_OFF_DMA_TRIG    5'h07
`define CX4_OFF_CACHE_TRIG  5'h08
`define CX4_R1F50_RESET     8'h33
`define CX4_R1F50_MASK      8'h77

`define CX4_WR_HISTORY      6      // nWR samples kept

`endif

// ==== rtl/cx4_cache_fill.sv ====
`timescale 1ns/100ps
`include "cx4_defs_defs.svh"

module cx4_cache_fill import cx4_pkg::*; (
  input  logic                    CLK,
  input  logic                    rst,
  input  logic                    go,
  input  mmio_regs_t              regs,
  input  logic                    BUS_RDY,
  input  logic [`CX4_DATA_W-1:0]  BUS_DI,
  output bus_req_t                req,
  output ram_wr_t                 pgm_wr,
  output logic                    busy,
  input  logic [1:0]              tag_sel,
  output logic [7:0]              tag_do
);

  xfer_state_e                state;
  cache_tag_t                 tags [2];
  logic                       hit;
  logic                       rrq;
  logic                       we;
  logic                       take;
  logic                       slot;
  logic [`CX4_PAGE_NUM_W-1:0] page;
  logic [`CX4_WORD_W-1:0]     src;
  logic [`CX4_PGM_AW-1:0]     pgm_addr;
  logic [`CX4_PAGE_AW:0]      count;  // bytes done
  logic [`CX4_DATA_W-1:0]     data;

  assign hit  = tags[regs.cache_page].valid && (tags[regs.cache_page].page == regs.pgm_page);
  assign take = (state == xs_wait) && !rrq && BUS_RDY;

  ////////////////////////////////////////
  // control and tags
  ////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (rst) begin
      state   <= xs_idle;
      busy    <= 1'b0;
      rrq     <= 1'b0;
      we      <= 1'b0;
      tags[0] <= '0;
      tags[1] <= '0;
    end else begin
      case (state)
        xs_idle: if (go && !hit) state <= xs_start;  // page already there
        xs_start: begin
          busy  <= 1'b1;
          rrq   <= 1'b1;
          state <= xs_wait;
        end
        xs_wait: begin
          rrq <= 1'b0;
          if (take) begin
            we    <= 1'b1;
            state <= xs_step;
          end
        end
        xs_step: begin
          we <= 1'b0;
          if (count == (1 << `CX4_PAGE_AW)) begin
            busy       <= 1'b0;
            tags[slot] <= '{valid: 1'b1, page: page};
            state      <= xs_idle;
          end else begin
            rrq   <= 1'b1;
            state <= xs_wait;
          end
        end
        default: state <= xs_idle;
      endcase
    end
  end

  // datapath
  always_ff @(posedge CLK) begin
    case (state)
      xs_idle: begin
        slot <= regs.cache_page;
        page <= regs.pgm_page;
      end
      xs_start: begin
        src      <= regs.pgm_off + {page, {`CX4_PAGE_AW{1'b0}}};
        pgm_addr <= {slot, {`CX4_PAGE_AW{1'b0}}};
        count    <= '0;
      end
      xs_wait: if (take) begin
        data  <= BUS_DI;
        count <= count + 1'b1;
      end
      xs_step: begin
        src      <= src + 1'b1;
        pgm_addr <= pgm_addr + 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLK) begin
    case (tag_sel)
      2'd0: tag_do <= tags[0][15:8];
      2'd1: tag_do <= tags[0][7:0];
      2'd2: tag_do <= tags[1][15:8];
      default: tag_do <= tags[1][7:0];
    endcase
  end

  assign req    = '{rrq: rrq, addr: src};
  assign pgm_wr = '{we: we, addr: `CX4_DATRAM_AW'(pgm_addr), data: data};

endmodule

// ==== rtl/cx4_dma_engine.sv ====
`timescale 1ns/100ps
`include "cx4_defs_defs.svh"

module cx4_dma_engine import cx4_pkg::*; (
  input  logic                    CLK,
  input  logic                    rst,
  input  logic                    go,
  input  mmio_regs_t              regs,
  input  logic                    BUS_RDY,
  input  logic [`CX4_DATA_W-1:0]  BUS_DI,
  output bus_req_t                req,
  output ram_wr_t                 ram_wr,
  output logic                    busy
);

  xfer_state_e               state;
  logic                      rrq;
  logic                      we;
  logic [`CX4_WORD_W-1:0]    src;
  logic [`CX4_DATRAM_AW-1:0] tgt;
  logic [15:0]               count;  // 0 means 64k
  logic [`CX4_DATA_W-1:0]    data;
  logic                      take;

  assign take = (state == xs_wait) && !rrq && BUS_RDY;  // rdy ignored in pulse cycle

  // control
  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= xs_idle;
      busy  <= 1'b0;
      rrq   <= 1'b0;
      we    <= 1'b0;
    end else begin
      case (state)
        xs_idle: if (go) state <= xs_start;
        xs_start: begin
          busy  <= 1'b1;
          rrq   <= 1'b1;
          state <= xs_wait;
        end
        xs_wait: begin
          rrq <= 1'b0;
          if (take) begin
            we    <= 1'b1;
            state <= xs_step;
          end
        end
        xs_step: begin
          we <= 1'b0;
          if (count == 16'h0000) begin
            busy  <= 1'b0;
            state <= xs_idle;
          end else begin
            rrq   <= 1'b1;
            state <= xs_wait;
          end
        end
        default: state <= xs_idle;
      endcase
    end
  end

  // datapath
  always_ff @(posedge CLK) begin
    if (state == xs_start) begin
      src   <= regs.dma_src;
      tgt   <= regs.dma_tgt[`CX4_DATRAM_AW-1:0];
      count <= regs.dma_len;
    end else if (take) begin
      data  <= BUS_DI;
      count <= count - 1'b1;
    end else if (state == xs_step) begin
      src <= src + 1'b1;
      tgt <= tgt + 1'b1;
    end
  end

  assign req    = '{rrq: rrq, addr: src};
  assign ram_wr = '{we: we, addr: tgt, data: data};

endmodule

// ==== rtl/cx4_dual_ram.sv ====
`timescale 1ns/100ps
`include "cx4_defs_defs.svh"

module cx4_dual_ram import cx4_pkg::*; #(
  parameter int AW    = `CX4_DATRAM_AW,
  parameter int WORDS = `CX4_DATRAM_BYTES
) (
  input  logic                    CLK,
  input  ram_wr_t                 a_wr,
  input  ram_wr_t                 b_wr,
  output logic [`CX4_DATA_W-1:0]  a_do,
  output logic [`CX4_DATA_W-1:0]  b_do
);

  logic [`CX4_DATA_W-1:0] mem [WORDS];
  logic [AW-1:0]          a_addr;
  logic [AW-1:0]          b_addr;

  assign a_addr = a_wr.addr[AW-1:0];
  assign b_addr = b_wr.addr[AW-1:0];

  // reads return the old byte on a same-cycle write
  always_ff @(posedge CLK) begin
    if (a_wr.we && (a_addr < WORDS)) begin
      mem[a_addr] <= a_wr.data;
    end
    if (b_wr.we && (b_addr < WORDS)) begin
      mem[b_addr] <= b_wr.data;
    end
    a_do <= mem[a_addr];
    b_do <= mem[b_addr];
  end

endmodule

// ==== rtl/cx4_host_port.sv ====
`timescale 1ns/100ps
`include "cx4_defs_defs.svh"

module cx4_host_port import cx4_pkg::*; (
  input  logic                    CLK,
  input  logic                    rst,
  input  logic [`CX4_ADDR_W-1:0]  ADDR,
  input  logic                    CS,
  input  logic                    nWR,
  input  logic [`CX4_DATA_W-1:0]  DI,
  input  logic [7:0]              regs_do,
  input  logic [7:0]              datram_do,
  input  logic [7:0]              tag_do,
  input  logic [1:0]              busy,
  output host_wr_t                wr,
  output ram_wr_t                 datram_wr,
  output logic [7:0]              DO
);

  localparam logic [7:0] MMIO_PAGE = 8'(`CX4_MMIO_BASE >> 5);
  localparam logic [`CX4_WR_HISTORY-1:0] WR_PATTERN = {1'b1, {(`CX4_WR_HISTORY-1){1'b0}}};

  logic [`CX4_WR_HISTORY-1:0] wr_hist;
  logic                       wr_en;
  host_region_e               region;
  logic                       active;
  logic [7:0]                 status;

  ////////////////////////////////////////
  // write strobe
  ////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (rst) begin
      wr_hist <= '1;
    end else begin
      wr_hist <= {wr_hist[`CX4_WR_HISTORY-2:0], nWR};  // newest in bit 0
    end
  end

  assign wr_en = (wr_hist == WR_PATTERN);  // one high, then five low

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////
  always_comb begin
    region = rgn_none;
    if (CS) begin
      if (ADDR[11:0] < `CX4_DATRAM_BYTES) begin
        region = rgn_datram;
      end else if (ADDR[12:5] == MMIO_PAGE) begin
        region = (ADDR[4:0] <= `CX4_MMIO_LAST) ? rgn_mmio : rgn_status;
      end else if (&ADDR[12:7] && &ADDR[5:4]) begin
        region = rgn_tag;  // 0x1fb0 / 0x1ff0
      end
    end
  end

  assign wr = '{strobe: wr_en && (region == rgn_mmio), addr: ADDR, data: DI};

  assign datram_wr = '{
    we:   wr_en && (region == rgn_datram),
    addr: ADDR[`CX4_DATRAM_AW-1:0],  // also the read address
    data: DI
  };

  // read side
  assign active = |busy;
  assign status = {1'b0, active, 4'b0000, ~active, 1'b0};

  always_comb begin
    case (region)
      rgn_datram: DO = datram_do;
      rgn_mmio:   DO = regs_do;
      rgn_status: DO = status;
      rgn_tag:    DO = tag_do;
      default:    DO = 8'h00;
    endcase
  end

endmodule

// ==== rtl/cx4_mmio_regs.sv ====
`timescale 1ns/100ps
`include "cx4_defs_defs.svh"

module cx4_mmio_regs import cx4_pkg::*; (
  input  logic        CLK,
  input  logic        rst,
  input  host_wr_t    wr,
  input  logic [4:0]  rd_off,
  output mmio_regs_t  regs,
  output logic        dma_go,
  output logic        cache_go,
  output logic [7:0]  regs_do
);

  logic [4:0]             wr_off;
  logic [`CX4_DATA_W-1:0] d;

  assign wr_off = wr.addr[4:0];
  assign d      = wr.data;

  ////////////////////////////////////////
  // register writes
  ////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (rst) begin
      regs       <= '0;
      regs.r1f50 <= `CX4_R1F50_RESET;
      regs.r1f52 <= 1'b1;
      dma_go     <= 1'b0;
      cache_go   <= 1'b0;
    end else begin
      dma_go   <= wr.strobe && (wr_off == `CX4_OFF_DMA_TRIG);
      cache_go <= wr.strobe && (wr_off == `CX4_OFF_CACHE_TRIG);
      if (wr.strobe) begin
        case (wr_off)
          5'h00: regs.dma_src[7:0]   <= d;
          5'h01: regs.dma_src[15:8]  <= d;
          5'h02: regs.dma_src[23:16] <= d;
          5'h03: regs.dma_len[7:0]   <= d;
          5'h04: regs.dma_len[15:8]  <= d;
          5'h05: regs.dma_tgt[7:0]   <= d;
          5'h06: regs.dma_tgt[15:8]  <= d;
          5'h07: regs.dma_tgt[23:16] <= d;     // also starts dma
          5'h08: regs.cache_page     <= d[0];  // also starts fill
          5'h09: regs.pgm_off[7:0]   <= d;
          5'h0a: regs.pgm_off[15:8]  <= d;
          5'h0b: regs.pgm_off[23:16] <= d;
          5'h0c: regs.r1f4c          <= d[1:0];
          5'h0d: regs.pgm_page[7:0]  <= d;
          5'h0e: regs.pgm_page[14:8] <= d[6:0];
          5'h0f: regs.pc             <= d;
          5'h10: regs.r1f50          <= d & `CX4_R1F50_MASK;
          5'h11: regs.r1f51          <= d[0];
          5'h12: regs.r1f52          <= d[0];
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // read back
  ////////////////////////////////////////
  always_ff @(posedge CLK) begin
    case (rd_off)
      5'h00: regs_do <= regs.dma_src[7:0];
      5'h01: regs_do <= regs.dma_src[15:8];
      5'h02: regs_do <= regs.dma_src[23:16];
      5'h03: regs_do <= regs.dma_len[7:0];
      5'h04: regs_do <= regs.dma_len[15:8];
      5'h05: regs_do <= regs.dma_tgt[7:0];
      5'h06: regs_do <= regs.dma_tgt[15:8];
      5'h07: regs_do <= regs.dma_tgt[23:16];
      5'h08: regs_do <= {7'b0, regs.cache_page};
      5'h09: regs_do <= regs.pgm_off[7:0];
      5'h0a: regs_do <= regs.pgm_off[15:8];
      5'h0b: regs_do <= regs.pgm_off[23:16];
      5'h0c: regs_do <= {6'b0, regs.r1f4c};
      5'h0d: regs_do <= regs.pgm_page[7:0];
      5'h0e: regs_do <= {1'b0, regs.pgm_page[14:8]};
      5'h0f: regs_do <= regs.pc;
      5'h10: regs_do <= regs.r1f50;
      5'h11: regs_do <= {7'b0, regs.r1f51};
      5'h12: regs_do <= {7'b0, regs.r1f52};
      default: regs_do <= 8'hff;  // unmapped
    endcase
  end

endmodule

// ==== rtl/cx4_pkg.sv ====
`include "cx4_defs_defs.svh"

package cx4_pkg;

  typedef enum logic [2:0] {
    rgn_none,
    rgn_datram,
    rgn_mmio,
    rgn_status,
    rgn_tag
  } host_region_e;

  typedef enum logic [1:0] {
    xs_idle,
    xs_start,
    xs_wait,
    xs_step
  } xfer_state_e;

  typedef struct packed {
    logic                    strobe;
    logic [`CX4_ADDR_W-1:0]  addr;
    logic [`CX4_DATA_W-1:0]  data;
  } host_wr_t;

  typedef struct packed {
    logic [`CX4_WORD_W-1:0]      dma_src;
    logic [15:0]                 dma_len;
    logic [`CX4_WORD_W-1:0]      dma_tgt;
    logic                        cache_page;  // slot select
    logic [`CX4_WORD_W-1:0]      pgm_off;
    logic [1:0]                  r1f4c;
    logic [`CX4_PAGE_NUM_W-1:0]  pgm_page;
    logic [7:0]                  pc;          // storage only
    logic [7:0]                  r1f50;
    logic                        r1f51;
    logic                        r1f52;
  } mmio_regs_t;

  typedef struct packed {
    logic                       we;
    logic [`CX4_DATRAM_AW-1:0]  addr;
    logic [`CX4_DATA_W-1:0]     data;
  } ram_wr_t;

  typedef struct packed {
    logic                    rrq;
    logic [`CX4_WORD_W-1:0]  addr;
  } bus_req_t;

  typedef struct packed {
    logic                        valid;
    logic [`CX4_PAGE_NUM_W-1:0]  page;
  } cache_tag_t;

endpackage

// ==== rtl/cx4_top.sv ====
`timescale 1ns/100ps
`include "cx4_defs_defs.svh"

module cx4_top import cx4_pkg::*; (
  input  logic                        CLK,
  input  logic                        rst,
  input  logic [`CX4_DATA_W-1:0]      DI,
  output logic [`CX4_DATA_W-1:0]      DO,
  input  logic [`CX4_ADDR_W-1:0]      ADDR,
  input  logic                        CS,
  input  logic                        nRD,
  input  logic                        nWR,
  input  logic [`CX4_DATA_W-1:0]      BUS_DI,
  output logic [`CX4_BUS_ADDR_W-1:0]  BUS_ADDR,
  output logic                        BUS_RRQ,
  input  logic                        BUS_RDY,
  output logic                        cx4_active,
  input  logic [`CX4_PGM_AW-1:0]      prg_rd_addr,
  output logic [`CX4_DATA_W-1:0]      prg_rd_data
);

  host_wr_t   host_wr;
  ram_wr_t    datram_host_wr;
  ram_wr_t    datram_dma_wr;
  ram_wr_t    pgm_fill_wr;
  ram_wr_t    pgm_fetch;
  mmio_regs_t regs;
  bus_req_t   dma_req;
  bus_req_t   cache_req;
  bus_req_t   bus_req;
  logic [7:0] regs_do;
  logic [7:0] datram_do;
  logic [7:0] tag_do;
  logic       dma_go;
  logic       cache_go;
  logic       dma_busy;
  logic       cache_busy;

  ////////////////////////////////////////
  // host side
  ////////////////////////////////////////
  cx4_host_port u_host (
    .CLK, .rst, .ADDR, .CS, .nWR, .DI,
    .regs_do, .datram_do, .tag_do,
    .busy({dma_busy, cache_busy}),
    .wr(host_wr), .datram_wr(datram_host_wr), .DO
  );

  cx4_mmio_regs u_regs (
    .CLK, .rst, .wr(host_wr), .rd_off(ADDR[4:0]),
    .regs, .dma_go, .cache_go, .regs_do
  );

  ////////////////////////////////////////
  // transfer engines
  ////////////////////////////////////////
  cx4_dma_engine u_dma (
    .CLK, .rst, .go(dma_go), .regs, .BUS_RDY, .BUS_DI,
    .req(dma_req), .ram_wr(datram_dma_wr), .busy(dma_busy)
  );

  cx4_cache_fill u_cache (
    .CLK, .rst, .go(cache_go), .regs, .BUS_RDY, .BUS_DI,
    .req(cache_req), .pgm_wr(pgm_fill_wr), .busy(cache_busy),
    .tag_sel(ADDR[1:0]), .tag_do
  );

  assign bus_req    = cache_busy ? cache_req : dma_req;  // cache wins
  assign BUS_RRQ    = cache_req.rrq | dma_req.rrq;
  assign BUS_ADDR   = {bus_req.addr[23:16], bus_req.addr[14:0]};
  assign cx4_active = dma_busy | cache_busy;

  // memories
  cx4_dual_ram #(.AW(`CX4_DATRAM_AW), .WORDS(`CX4_DATRAM_BYTES)) u_datram (
    .CLK, .a_wr(datram_host_wr), .b_wr(datram_dma_wr), .a_do(datram_do), .b_do()
  );

  assign pgm_fetch = '{we: 1'b0, addr: `CX4_DATRAM_AW'(prg_rd_addr), data: '0};

  cx4_dual_ram #(.AW(`CX4_PGM_AW), .WORDS(1 << `CX4_PGM_AW)) u_pgmram (
    .CLK, .a_wr(pgm_fill_wr), .b_wr(pgm_fetch), .a_do(), .b_do(prg_rd_data)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cx4_tb -o cx4_sim -f flist.f \
  || exit 1
out="$(./obj_dir/cx4_sim)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1

// ==== verification/cx4_bus_model.sv ====
`timescale 1ns/100ps
`include "cx4_defs_defs.svh"

module cx4_bus_model (
  input  logic                        CLK,
  input  logic                        rst,
  input  logic                        BUS_RRQ,
  input  logic [`CX4_BUS_ADDR_W-1:0]  BUS_ADDR,
  output logic                        BUS_RDY,
  output logic [`CX4_DATA_W-1:0]      BUS_DI
);

  int unsigned                 seed = 15243;
  logic [2:0]                  delay;
  logic [`CX4_BUS_ADDR_W-1:0]  addr_q;

  function automatic int unsigned lcg_next(input int unsigned s);
    return (s * 32'd1103515245 + 32'd12345) & 32'h7fff_ffff;
  endfunction

  ////////////////////////////////////////
  // read responder
  ////////////////////////////////////////
  always @(posedge CLK) begin
    if (rst) begin
      BUS_RDY <= 1'b1;
      BUS_DI  <= '0;
      delay   <= '0;
      addr_q  <= '0;
    end else if (BUS_RRQ) begin
      seed = lcg_next(seed);
      BUS_RDY <= 1'b0;                      // busy from this edge on
      addr_q  <= BUS_ADDR;
      delay   <= 3'(2 + ((seed >> 16) % 4));  // 2 to 5 cycles low
    end else if (delay != 3'd0) begin
      delay <= delay - 3'd1;
      if (delay == 3'd1) begin
        BUS_RDY <= 1'b1;
        BUS_DI  <= addr_q[7:0] ^ addr_q[15:8];  // data follows the address
      end
    end
  end

endmodule

// ==== verification/cx4_tb.sv ====
`timescale 1ns/100ps
`include "cx4_defs_defs.svh"

module cx4_tb;

  typedef enum logic [2:0] {
    op_wr,       // host write
    op_rd,       // host read and compare
    op_active,   // wait for busy, then read status
    op_idle,     // wait for busy to fall
    op_dma_chk,  // addr source, data length, exp target
    op_pgm_chk,  // addr source, data length, exp program address
    op_quiet     // data cycles without a bus request
  } op_e;

  typedef struct packed {
    op_e          op;
    logic [23:0]  addr;
    logic [23:0]  data;
    logic [23:0]  exp;
  } step_t;

  localparam int N_STEPS = 41;

  logic                        CLK = 1'b0;
  logic                        rst;
  logic                        CS;
  logic                        nRD;
  logic                        nWR;
  logic [`CX4_ADDR_W-1:0]      ADDR;
  logic [`CX4_DATA_W-1:0]      DI;
  logic [`CX4_DATA_W-1:0]      DO;
  logic [`CX4_DATA_W-1:0]      BUS_DI;
  logic [`CX4_BUS_ADDR_W-1:0]  BUS_ADDR;
  logic                        BUS_RRQ;
  logic                        BUS_RDY;
  logic                        cx4_active;
  logic [`CX4_PGM_AW-1:0]      prg_rd_addr;
  logic [`CX4_DATA_W-1:0]      prg_rd_data;

  logic [`CX4_BUS_ADDR_W-1:0]  req_addrs [$];  // external requests, in order

  int checks = 0;
  int mismatches = 0;
  int timeouts = 0;

  step_t steps [N_STEPS] = '{
    '{op_rd, 24'h1f5e, 24'h00, 24'h02},  // idle status
    '{op_rd, 24'h1f50, 24'h00, 24'h33},
    '{op_rd, 24'h1fb0, 24'h00, 24'h00},
    '{op_rd, 24'h1fb1, 24'h00, 24'h00},
    '{op_rd, 24'h1fb2, 24'h00, 24'h00},
    '{op_rd, 24'h1fb3, 24'h00, 24'h00},
    '{op_wr, 24'h1f4f, 24'h5a, 24'h00},
    '{op_rd, 24'h1f4f, 24'h00, 24'h5a},
    '{op_wr, 24'h1f50, 24'hff, 24'h00},
    '{op_rd, 24'h1f50, 24'h00, 24'h77},  // masked
    '{op_rd, 24'h1f53, 24'h00, 24'hff},  // no register
    '{op_rd, 24'h1f52, 24'h00, 24'h01},
    '{op_wr, 24'h0123, 24'ha5, 24'h00},
    '{op_rd, 24'h0123, 24'h00, 24'ha5},
    '{op_wr, 24'h0bff, 24'h3c, 24'h00},
    '{op_rd, 24'h0bff, 24'h00, 24'h3c},
    '{op_wr, 24'h1f40, 24'h00, 24'h00},  // dma source 0x818000
    '{op_wr, 24'h1f41, 24'h80, 24'h00},
    '{op_wr, 24'h1f42, 24'h81, 24'h00},
    '{op_wr, 24'h1f43, 24'h14, 24'h00},  // 20 bytes
    '{op_wr, 24'h1f44, 24'h00, 24'h00},
    '{op_wr, 24'h1f45, 24'h00, 24'h00},
    '{op_wr, 24'h1f46, 24'h01, 24'h00},
    '{op_wr, 24'h1f47, 24'h00, 24'h00},  // starts dma
    '{op_active, 24'h1f5e, 24'h00, 24'h40},
    '{op_idle, 24'h0000, 24'h00, 24'h00},
    '{op_dma_chk, 24'h818000, 24'd20, 24'h100},
    '{op_wr, 24'h1f49, 24'h00, 24'h00},  // program offset 0x00a400
    '{op_wr, 24'h1f4a, 24'ha4, 24'h00},
    '{op_wr, 24'h1f4b, 24'h00, 24'h00},
    '{op_wr, 24'h1f4d, 24'h03, 24'h00},  // page 3
    '{op_wr, 24'h1f4e, 24'h00, 24'h00},
    '{op_wr, 24'h1f48, 24'h01, 24'h00},  // fill slot 1
    '{op_active, 24'h1f5e, 24'h00, 24'h40},
    '{op_idle, 24'h0000, 24'h00, 24'h00},
    '{op_rd, 24'h1fb2, 24'h00, 24'h80},
    '{op_rd, 24'h1fb3, 24'h00, 24'h03},
    '{op_pgm_chk, 24'h00aa00, 24'd512, 24'h200},
    '{op_wr, 24'h1f48, 24'h01, 24'h00},  // same page again
    '{op_quiet, 24'h0000, 24'd100, 24'h00},
    '{op_rd, 24'h1f5e, 24'h00, 24'h02}
  };

  always #5 CLK = ~CLK;

  cx4_top UUT (
    .CLK, .rst, .DI, .DO, .ADDR, .CS, .nRD, .nWR,
    .BUS_DI, .BUS_ADDR, .BUS_RRQ, .BUS_RDY, .cx4_active,
    .prg_rd_addr, .prg_rd_data
  );

  cx4_bus_model bus_model (
    .CLK, .rst, .BUS_RRQ, .BUS_ADDR, .BUS_RDY, .BUS_DI
  );

  always @(negedge CLK) begin
    if (BUS_RRQ === 1'b1) begin
      req_addrs.push_back(BUS_ADDR);
    end
  end

  // external address for a 24-bit engine address, bit 15 dropped
  function automatic logic [22:0] mapped_addr(input logic [23:0] a);
    return {a[23:16], a[14:0]};
  endfunction

  // byte the external bus returns for a 24-bit engine address
  function automatic logic [7:0] bus_byte(input logic [23:0] a);
    logic [22:0] m;
    m = mapped_addr(a);
    return m[7:0] ^ m[15:8];
  endfunction

  ////////////////////////////////////////
  // host access
  ////////////////////////////////////////
  task automatic host_write(input logic [12:0] a, input logic [7:0] d);
    @(posedge CLK);
    ADDR <= a;
    DI   <= d;
    nWR  <= 1'b0;
    repeat (10) @(posedge CLK);
    nWR <= 1'b1;
    repeat (4) @(posedge CLK);
  endtask

  task automatic host_read(input logic [12:0] a, output logic [7:0] d);
    @(posedge CLK);
    ADDR <= a;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    d = DO;
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    assert (got === exp) else begin
      mismatches++;
      $display("mismatch at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [23:0] got,
                            input logic [23:0] exp);
    checks++;
    assert (got === exp) else begin
      mismatches++;
      $display("mismatch at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic wait_active(input bit level, input int limit);
    int n;
    n = 0;
    while (cx4_active !== level && n < limit) begin
      @(negedge CLK);
      n++;
    end
    assert (cx4_active === level) else begin
      timeouts++;
      $display("timeout at %0t: cx4_active did not go %s within %0d cycles",
               $time, level ? "high" : "low", limit);
    end
  endtask

  ////////////////////////////////////////
  // table steps
  ////////////////////////////////////////
  task automatic run_step(input step_t s);
    logic [7:0] got;
    logic       seen_active;
    case (s.op)
      op_wr: host_write(s.addr[12:0], s.data[7:0]);
      op_rd: begin
        host_read(s.addr[12:0], got);
        check_byte($sformatf("DO[0x%h]", s.addr[12:0]), got, s.exp[7:0]);
      end
      op_active: begin
        wait_active(1'b1, 50);
        host_read(s.addr[12:0], got);
        check_byte($sformatf("DO[0x%h]", s.addr[12:0]), got, s.exp[7:0]);
        check_byte("cx4_active", {7'b0, cx4_active}, 8'h01);  // still running
      end
      op_idle: wait_active(1'b0, 10000);
      op_dma_chk: begin
        check_word("bus request count", 24'(req_addrs.size()), s.data);
        for (int i = 0; i < req_addrs.size() && i < int'(s.data); i++) begin
          check_word($sformatf("BUS_ADDR[%0d]", i), 24'(req_addrs[i]),
                     24'(mapped_addr(s.addr + 24'(i))));
        end
        req_addrs.delete();
        for (int i = 0; i < int'(s.data); i++) begin
          host_read(13'(s.exp + 24'(i)), got);
          check_byte($sformatf("DO[0x%h]", 13'(s.exp + 24'(i))), got,
                     bus_byte(s.addr + 24'(i)));
        end
      end
      op_pgm_chk: begin
        check_word("bus request count", 24'(req_addrs.size()), s.data);
        for (int i = 0; i < req_addrs.size() && i < int'(s.data); i++) begin
          check_word($sformatf("BUS_ADDR[%0d]", i), 24'(req_addrs[i]),
                     24'(mapped_addr(s.addr + 24'(i))));
        end
        req_addrs.delete();
        for (int i = 0; i < int'(s.data); i++) begin
          @(posedge CLK);
          prg_rd_addr <= 10'(s.exp + 24'(i));
          repeat (2) @(posedge CLK);
          @(negedge CLK);
          check_byte($sformatf("prg_rd_data[0x%h]", 10'(s.exp + 24'(i))), prg_rd_data,
                     bus_byte(s.addr + 24'(i)));
        end
      end
      op_quiet: begin
        seen_active = 1'b0;
        repeat (int'(s.data)) begin
          @(negedge CLK);
          seen_active = seen_active | cx4_active;
        end
        check_word("bus request count", 24'(req_addrs.size()), 24'h0);  // since the trigger
        check_byte("cx4_active", {7'b0, seen_active}, 8'h00);
      end
      default: ;
    endcase
  endtask

  initial begin
    rst         = 1'b1;
    CS          = 1'b1;
    nRD         = 1'b1;
    nWR         = 1'b1;
    ADDR        = '0;
    DI          = '0;
    prg_rd_addr = '0;
    repeat (10) @(posedge CLK);
    rst <= 1'b0;
    @(negedge CLK);
    check_byte("cx4_active", {7'b0, cx4_active}, 8'h00);

    for (int i = 0; i < N_STEPS && timeouts == 0; i++) begin
      run_step(steps[i]);
    end

    $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
